// File: hw/ExecPkg.sv
// Shared types and codes for the execute lane; imported by every RTL file and the testbench
package ExecPkg;

	// Micro-op codes as they arrive from the testbench
	typedef enum logic [3:0] {
		uCmdNop   = 4'h0,	// Bubble
		uCmdAlu3  = 4'h1,	// Rm = Rs op Rt
		uCmdLoad  = 4'h2,	// Rm = mem[Rs + imm]
		uCmdStore = 4'h3,	// mem[Rs + imm] = Rm
		uCmdMul3  = 4'h4,	// Rm = low 64 of Rs * Rt
		uCmdMovRc = 4'h5	// Control reg Rm = Rs
	} uCmdT;

	// ALU function, carried on opUIxt
	typedef enum logic [2:0] {
		aluAdd = 3'h0,
		aluSub = 3'h1,
		aluAnd = 3'h2,
		aluOr  = 3'h3,
		aluXor = 3'h4
	} aluFnT;

	// 0..31 general, 32..63 control
	typedef logic [5:0] regIdT;

	// Destination that means no write; also reads as zero
	localparam regIdT regZzr = 6'd0;

	// Status returned by the data memory
	typedef enum logic [1:0] {
		memReady = 2'b00,	// Data valid or write done
		memHold  = 2'b10,	// Access still pending
		memFault = 2'b11	// Address out of range
	} memOkT;

	typedef logic [63:0] wordT;

endpackage

// File: hw/ExStageIf.sv
// In-flight op state between two execute stages; src on the registering stage, dst on the reader
`timescale 1ns/1ps

interface ExStageIf import ExecPkg::*; ();

	uCmdT uCmd;			// Op code, NOP for a bubble
	logic flush;		// Op is to be nullified in stage 3
	regIdT regIdRn;		// GPR destination
	wordT regValRn;		// GPR value
	regIdT regIdCn;		// Control reg destination
	wordT regValCn;		// Control reg value
	wordT auxA;			// Mul cross product lo*hi, or mem address
	wordT auxB;			// Mul cross product hi*lo, or store data

	modport src (
		output uCmd, flush,
		output regIdRn, regValRn,
		output regIdCn, regValCn,
		output auxA, auxB
	);

	modport dst (
		input uCmd, flush,
		input regIdRn, regValRn,
		input regIdCn, regValCn,
		input auxA, auxB
	);

endinterface

// File: hw/ExEx1.sv
// Execute stage 1: ALU, address generation and multiply partial products into the s12 link
`timescale 1ns/1ps

module ExEx1 import ExecPkg::*; (
	input logic clock,
	input logic reset,
	input logic hold,
	input logic issue,
	input uCmdT opUCmd,
	input aluFnT opUIxt,
	input logic flush,
	input regIdT regIdRs,		// Source A, ALU / base
	input regIdT regIdRt,		// Source B, ALU / mul
	input regIdT regIdRm,		// Dest, or store data source
	input wordT regValRs,
	input wordT regValRt,
	input wordT regValRm,
	input wordT regValImm,		// Address displacement
	ExStageIf.src s12
);

	wordT srcA;
	wordT srcB;
	wordT srcM;
	wordT aluRes;
	uCmdT opCmd;
	uCmdT nextCmd;
	regIdT nextIdRn;
	regIdT nextIdCn;
	wordT nextValRn;
	wordT nextValCn;
	wordT nextAuxA;
	wordT nextAuxB;

	// Zero register reads as zero
	assign srcA = (regIdRs == regZzr) ? '0 : regValRs;
	assign srcB = (regIdRt == regZzr) ? '0 : regValRt;
	assign srcM = (regIdRm == regZzr) ? '0 : regValRm;

	assign opCmd = issue ? opUCmd : uCmdNop;	// No issue means bubble

	always_comb begin
		case (opUIxt)
			aluAdd: aluRes = srcA + srcB;
			aluSub: aluRes = srcA - srcB;
			aluAnd: aluRes = srcA & srcB;
			aluOr: aluRes = srcA | srcB;
			aluXor: aluRes = srcA ^ srcB;
			default: aluRes = srcA + srcB;	// Unused codes act as add
		endcase
	end

	always_comb begin
		nextCmd = opCmd;
		nextIdRn = regZzr;
		nextIdCn = regZzr;
		nextValRn = '0;
		nextValCn = '0;
		nextAuxA = '0;
		nextAuxB = '0;
		case (opCmd)
			uCmdAlu3: begin
				nextIdRn = regIdRm;
				nextValRn = aluRes;
			end
			uCmdLoad: begin
				nextIdRn = regIdRm;			// Value filled in stage 3
				nextAuxA = srcA + regValImm;
			end
			uCmdStore: begin
				nextAuxA = srcA + regValImm;
				nextAuxB = srcM;			// Store data from Rm
			end
			uCmdMul3: begin
				nextIdRn = regIdRm;
				nextValRn = 64'(srcA[31:0]) * 64'(srcB[31:0]);	// lo*lo
				nextAuxA = 64'(srcA[31:0]) * 64'(srcB[63:32]);	// lo*hi
				nextAuxB = 64'(srcA[63:32]) * 64'(srcB[31:0]);	// hi*lo
			end
			uCmdMovRc: begin
				nextIdCn = regIdRm;			// Rm names the control reg
				nextValCn = srcA;
			end
			uCmdNop: begin
			end
			default: nextCmd = uCmdNop;		// Unknown ops dropped
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			s12.uCmd <= uCmdNop;
			s12.flush <= 1'b0;
			s12.regIdRn <= regZzr;
			s12.regIdCn <= regZzr;
		end else if (!hold) begin
			s12.uCmd <= nextCmd;
			s12.flush <= issue && flush;
			s12.regIdRn <= nextIdRn;
			s12.regIdCn <= nextIdCn;
		end
		if (!hold) begin	// Payload follows the op
			s12.regValRn <= nextValRn;
			s12.regValCn <= nextValCn;
			s12.auxA <= nextAuxA;
			s12.auxB <= nextAuxB;
		end
	end

endmodule

// File: hw/ExEx2.sv
// Execute stage 2: multiply sum and memory request, registered into the s23 link
`timescale 1ns/1ps

module ExEx2 import ExecPkg::*; (
	input logic clock,
	input logic reset,
	input logic hold,
	ExStageIf.dst s12,
	ExStageIf.src s23,
	output logic memRead,
	output logic memWrite,
	output wordT memAddr,		// Word index
	output wordT memWData
);

	wordT crossSum;
	wordT mulLow;
	wordT nextValRn;
	logic isMul;

	assign isMul = (s12.uCmd == uCmdMul3);

	// Only the low 32 bits of the cross terms land in the low half
	assign crossSum = s12.auxA + s12.auxB;
	assign mulLow = s12.regValRn + (crossSum << 32);

	assign nextValRn = isMul ? mulLow : s12.regValRn;

	// Flushed memory ops never reach the memory
	assign memRead = (s12.uCmd == uCmdLoad) && !s12.flush;
	assign memWrite = (s12.uCmd == uCmdStore) && !s12.flush;
	assign memAddr = s12.auxA;
	assign memWData = s12.auxB;

	always_ff @(posedge clock) begin
		if (reset) begin
			s23.uCmd <= uCmdNop;
			s23.flush <= 1'b0;
			s23.regIdRn <= regZzr;
			s23.regIdCn <= regZzr;
		end else if (!hold) begin
			s23.uCmd <= s12.uCmd;
			s23.flush <= s12.flush;
			s23.regIdRn <= s12.regIdRn;
			s23.regIdCn <= s12.regIdCn;
		end
		if (!hold) begin
			s23.regValRn <= nextValRn;		// Final product for MUL3
			s23.regValCn <= s12.regValCn;
			s23.auxA <= s12.auxA;			// Address kept for stage 3
			s23.auxB <= s12.auxB;
		end
	end

endmodule

// File: hw/ExEx3.sv
// Third execute stage that selects the destination, stalls on memory wait and nullifies faults and flushes; instanced in ExLane
`timescale 1ns/1ps

module ExEx3 import ExecPkg::*; #(
	parameter int MemWords = 256,
	parameter int MemWaitCycles = 2
) (
	input logic clock,
	input logic reset,
	ExStageIf.dst s23,
	input memOkT memOk,
	input wordT memRData,
	output logic hold,			// Global pipeline stall
	output logic memFault,		// One-cycle fault pulse
	output regIdT regIdRn,
	output regIdT regIdCn,
	output wordT regValRn,
	output wordT regValCn
);

	logic isMemOp;
	logic isLoad;
	regIdT nextIdRn;
	regIdT nextIdCn;
	wordT nextValRn;

	assign isLoad = (s23.uCmd == uCmdLoad);
	assign isMemOp = (isLoad || s23.uCmd == uCmdStore) && !s23.flush;

	assign hold = isMemOp && (memOk == memHold);
	assign memFault = isMemOp && (memOk == ExecPkg::memFault);

	always_comb begin
		nextIdRn = s23.regIdRn;		// Forward by default
		nextIdCn = s23.regIdCn;
		nextValRn = s23.regValRn;
		if (isLoad) begin
			nextValRn = memRData;
		end
		// Faulted or flushed op writes nothing
		if (memFault || s23.flush) begin
			nextIdRn = regZzr;
			nextIdCn = regZzr;
		end
	end

	// Outputs stay put while the memory holds
	always_ff @(posedge clock) begin
		if (reset) begin
			regIdRn <= regZzr;
			regIdCn <= regZzr;
		end else if (!hold) begin
			regIdRn <= nextIdRn;
			regIdCn <= nextIdCn;
		end
		if (!hold) begin
			regValRn <= nextValRn;
			regValCn <= s23.regValCn;
		end
	end

	// Memory wait is bounded by the configured wait count
	assert property (@(posedge clock) disable iff (reset)
		hold [*(MemWaitCycles + 1)] |=> !hold)
		else $error("hold longer than MemWaitCycles+1 cycles");

	// Next op after a fault starts a fresh access or is no memory op
	assert property (@(posedge clock) disable iff (reset)
		memFault |=> !memFault)
		else $error("memFault longer than one cycle");

	// Completion status agrees with the address held in stage 3
	assert property (@(posedge clock) disable iff (reset)
		(isMemOp && !hold) |-> ((memOk == ExecPkg::memFault) == (s23.auxA >= 64'(MemWords))))
		else $error("memory status does not match address range");

endmodule

// File: hw/ExDataMem.sv
// Word-addressed data memory with fixed wait states and out-of-range fault, serving stage 2/3
`timescale 1ns/1ps

module ExDataMem import ExecPkg::*; #(
	parameter int MemWords = 256,
	parameter int MemWaitCycles = 2
) (
	input logic clock,
	input logic reset,
	input logic hold,
	input logic memRead,
	input logic memWrite,
	input wordT memAddr,
	input wordT memWData,
	output memOkT memOk,
	output wordT memRData
);

	localparam int CntW = $clog2(MemWaitCycles + 1) + 1;
	localparam int AddrW = $clog2(MemWords);

	wordT mem [MemWords];
	logic busy;					// Request captured, not yet retired
	logic [CntW-1:0] waitCnt;	// Wait cycles left
	logic capture;
	logic reqWrite;
	logic reqFault;
	logic [AddrW-1:0] reqIdx;
	wordT reqData;

	// Requests are taken as the op moves into stage 3
	assign capture = !hold && (memRead || memWrite);

	always_comb begin
		if (busy && waitCnt != '0) begin
			memOk = memHold;
		end else if (busy && reqFault) begin
			memOk = memFault;
		end else begin
			memOk = memReady;			// Also idle
		end
	end

	assign memRData = (busy && !reqFault) ? mem[reqIdx] : '0;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			waitCnt <= '0;
			for (int i = 0; i < MemWords; i++) begin
				mem[i] <= '0;
			end
		end else begin
			if (busy && waitCnt != '0) begin
				waitCnt <= waitCnt - 1'b1;
			end else if (busy) begin
				if (reqWrite && !reqFault) begin
					mem[reqIdx] <= reqData;	// Store lands on completion
				end
				busy <= 1'b0;
			end
			if (capture) begin			// Back-to-back with a retiring access
				busy <= 1'b1;
				waitCnt <= CntW'(MemWaitCycles);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (capture) begin
			reqWrite <= memWrite;
			reqFault <= (memAddr >= 64'(MemWords));
			reqIdx <= memAddr[AddrW-1:0];
			reqData <= memWData;
		end
	end

	// Stall from stage 3 must keep new requests out during wait states
	assert property (@(posedge clock) disable iff (reset)
		capture |-> !(busy && waitCnt != '0))
		else $error("new memory request while busy");

endmodule

// File: hw/ExLane.sv
// Execute lane top level: three stages and the data memory, plain ports for the testbench
`timescale 1ns/1ps

module ExLane import ExecPkg::*; #(
	parameter int MemWords = 256,
	parameter int MemWaitCycles = 2
) (
	input logic clock,
	input logic reset,
	input logic issue,
	input uCmdT opUCmd,
	input aluFnT opUIxt,
	input logic flush,
	input regIdT regIdRs,
	input regIdT regIdRt,
	input regIdT regIdRm,
	input wordT regValRs,
	input wordT regValRt,
	input wordT regValRm,
	input wordT regValImm,
	output logic hold,
	output logic memFault,
	output regIdT regIdRn,
	output wordT regValRn,
	output regIdT regIdCn,
	output wordT regValCn
);

	ExStageIf s12 ();		// EX1 -> EX2
	ExStageIf s23 ();		// EX2 -> EX3

	logic memRead;
	logic memWrite;
	wordT memAddr;
	wordT memWData;
	wordT memRData;
	memOkT memOk;

	ExEx1 ex1 (
		.clock(clock), .reset(reset), .hold(hold), .issue(issue),
		.opUCmd(opUCmd), .opUIxt(opUIxt), .flush(flush),
		.regIdRs(regIdRs), .regIdRt(regIdRt), .regIdRm(regIdRm),
		.regValRs(regValRs), .regValRt(regValRt), .regValRm(regValRm),
		.regValImm(regValImm), .s12(s12.src)
	);

	ExEx2 ex2 (
		.clock(clock), .reset(reset), .hold(hold),
		.s12(s12.dst), .s23(s23.src),
		.memRead(memRead), .memWrite(memWrite),
		.memAddr(memAddr), .memWData(memWData)
	);

	ExEx3 #(.MemWords(MemWords), .MemWaitCycles(MemWaitCycles)) ex3 (
		.clock(clock), .reset(reset), .s23(s23.dst),
		.memOk(memOk), .memRData(memRData),
		.hold(hold), .memFault(memFault),
		.regIdRn(regIdRn), .regIdCn(regIdCn),
		.regValRn(regValRn), .regValCn(regValCn)
	);

	ExDataMem #(.MemWords(MemWords), .MemWaitCycles(MemWaitCycles)) dmem (
		.clock(clock), .reset(reset), .hold(hold),
		.memRead(memRead), .memWrite(memWrite),
		.memAddr(memAddr), .memWData(memWData),
		.memOk(memOk), .memRData(memRData)
	);

endmodule

// File: verification/ExLaneTb.sv
// Testbench for the execute lane: directed and random ops, reference model, output compare
`timescale 1ns/1ps

module ExLaneTb import ExecPkg::*; ();

	localparam int MemWords = 256;
	localparam int MemWaitCycles = 2;
	localparam int AddrW = $clog2(MemWords);
	localparam int NumDirected = 17;
	localparam int NumRandom = 300;
	localparam int TimeoutCycles = (NumDirected + NumRandom) * (3 + MemWaitCycles + 1) + 100;

	typedef struct packed {
		regIdT idRn;
		wordT valRn;
		regIdT idCn;
		wordT valCn;
	} resultT;

	logic clock;
	logic reset;
	logic issue;
	uCmdT opUCmd;
	aluFnT opUIxt;
	logic flush;
	regIdT regIdRs, regIdRt, regIdRm;
	wordT regValRs, regValRt, regValRm, regValImm;
	logic hold;
	logic memFault;
	regIdT regIdRn, regIdCn;
	wordT regValRn, regValCn;

	logic [31:0] rngState = 32'h552c;
	wordT modelMem [MemWords];		// Reference copy of the data memory
	resultT expQ [$];				// Expected writes in issue order
	resultT head;
	int faultsExpected = 0;
	int faultsSeen = 0;
	int cycleCount = 0;

	ExLane #(.MemWords(MemWords), .MemWaitCycles(MemWaitCycles)) dut0 (
		.clock(clock), .reset(reset), .issue(issue),
		.opUCmd(opUCmd), .opUIxt(opUIxt), .flush(flush),
		.regIdRs(regIdRs), .regIdRt(regIdRt), .regIdRm(regIdRm),
		.regValRs(regValRs), .regValRt(regValRt), .regValRm(regValRm),
		.regValImm(regValImm), .hold(hold), .memFault(memFault),
		.regIdRn(regIdRn), .regValRn(regValRn), .regIdCn(regIdCn), .regValCn(regValCn)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;	// 40 ns period
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// Expected register write of one op, zero ids when it writes nothing
	function automatic resultT modelOp(input uCmdT cmd, input aluFnT fn, input logic fl,
			input regIdT rs, input regIdT rt, input regIdT rm,
			input wordT vrs, input wordT vrt, input wordT vrm, input wordT imm);
		resultT res;
		wordT a;
		wordT b;
		wordT addr;
		res = '0;
		a = (rs == regZzr) ? '0 : vrs;		// r0 reads zero
		b = (rt == regZzr) ? '0 : vrt;
		addr = a + imm;
		if (!fl) begin						// Flushed op leaves no trace
			case (cmd)
				uCmdAlu3: begin
					res.idRn = rm;
					case (fn)
						aluAdd: res.valRn = a + b;
						aluSub: res.valRn = a - b;
						aluAnd: res.valRn = a & b;
						aluOr: res.valRn = a | b;
						default: res.valRn = a ^ b;
					endcase
				end
				uCmdMul3: begin
					res.idRn = rm;
					res.valRn = a * b;			// Low 64 bits kept
				end
				uCmdMovRc: begin
					res.idCn = rm;
					res.valCn = a;
				end
				uCmdLoad, uCmdStore: begin
					if (addr >= 64'(MemWords)) begin
						faultsExpected++;		// Out of range, no write
					end else if (cmd == uCmdStore) begin
						modelMem[addr[AddrW-1:0]] = (rm == regZzr) ? '0 : vrm;
					end else begin
						res.idRn = rm;
						res.valRn = modelMem[addr[AddrW-1:0]];
					end
				end
				default: begin
				end
			endcase
		end
		return res;
	endfunction

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic checkValue(input wordT got, input wordT want, input string what);
		if (got !== want) begin
			abortRun($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
				$time, what, got, want));
		end
	endtask

	// Drive one op on a falling edge once hold is low
	task automatic issueOp(uCmdT cmd, aluFnT fn, logic fl, regIdT rs, regIdT rt, regIdT rm,
			wordT vrs, wordT vrt, wordT vrm, wordT imm);
		resultT res;
		@(negedge clock);
		while (hold) begin
			issue = 1'b0;			// Refused while stalled
			@(negedge clock);
		end
		issue = 1'b1;
		opUCmd = cmd;
		opUIxt = fn;
		flush = fl;
		regIdRs = rs;
		regIdRt = rt;
		regIdRm = rm;
		regValRs = vrs;
		regValRt = vrt;
		regValRm = vrm;
		regValImm = imm;
		res = modelOp(cmd, fn, fl, rs, rt, rm, vrs, vrt, vrm, imm);
		if (res.idRn != regZzr || res.idCn != regZzr) begin
			expQ.push_back(res);
		end
	endtask

	task automatic memOp(uCmdT cmd, logic fl, regIdT rm, wordT data, wordT addr);
		issueOp(cmd, aluAdd, fl, 6'd1, 6'd0, rm, addr, '0, data, '0);	// Base in r1
	endtask

	task automatic randomOp();
		uCmdT cmd;
		regIdT rm;
		wordT addr;
		wordT imm;
		case (3'(nextRand()))
			3'd0: cmd = uCmdNop;
			3'd1, 3'd2: cmd = uCmdAlu3;
			3'd3, 3'd7: cmd = uCmdLoad;
			3'd4: cmd = uCmdStore;
			3'd5: cmd = uCmdMul3;
			default: cmd = uCmdMovRc;
		endcase
		rm = (cmd == uCmdMovRc) ? 6'(32 + nextRand() % 32) : 6'(nextRand() % 32);
		if (cmd == uCmdLoad || cmd == uCmdStore) begin
			// Small window so loads meet earlier stores, now and then past the end
			addr = (nextRand() % 8 == 0) ? 64'(MemWords + nextRand() % 16)
				: 64'(nextRand() % 32);
			imm = 64'(nextRand() % 8);
			issueOp(cmd, aluAdd, nextRand() % 16 == 0, 6'(1 + nextRand() % 31), 6'd0, rm,
				addr - imm, '0, {nextRand(), nextRand()}, imm);
		end else begin
			issueOp(cmd, aluFnT'(3'(nextRand() % 5)), nextRand() % 16 == 0,
				6'(nextRand() % 32), 6'(nextRand() % 32), rm,
				{nextRand(), nextRand()}, {nextRand(), nextRand()}, '0, '0);
		end
	endtask

	// Compare one result per cycle with hold low and a real destination
	always @(negedge clock) begin
		if (!reset && !hold) begin
			if (memFault) begin
				faultsSeen++;
			end
			if (regIdRn != regZzr || regIdCn != regZzr) begin
				if (expQ.size() == 0) begin
					abortRun("DUT wrote a register when no result was expected");
				end else begin
					head = expQ.pop_front();
					checkValue(64'(regIdRn), 64'(head.idRn), "regIdRn");
					checkValue(64'(regIdCn), 64'(head.idCn), "regIdCn");
					if (head.idRn != regZzr) begin
						checkValue(regValRn, head.valRn, "regValRn");
					end
					if (head.idCn != regZzr) begin
						checkValue(regValCn, head.valCn, "regValCn");
					end
				end
			end
		end
	end

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount > TimeoutCycles) begin
			abortRun($sformatf("Timeout after %0d cycles with %0d results never seen",
				cycleCount, expQ.size()));
		end
	end

	initial begin
		reset = 1'b1;
		issue = 1'b0;
		opUCmd = uCmdNop;
		opUIxt = aluAdd;
		flush = 1'b0;
		regIdRs = regZzr;
		regIdRt = regZzr;
		regIdRm = regZzr;
		regValRs = '0;
		regValRt = '0;
		regValRm = '0;
		regValImm = '0;
		for (int i = 0; i < MemWords; i++) begin
			modelMem[i] = '0;
		end
		repeat (10) @(negedge clock);
		reset = 1'b0;
		checkValue(64'(hold), '0, "hold after reset");
		checkValue(64'(regIdRn), '0, "regIdRn after reset");
		checkValue(64'(regIdCn), '0, "regIdCn after reset");
		// Store and read back, untouched word, out of range both ways
		memOp(uCmdStore, 1'b0, 6'd3, 64'hdead_beef_0123_4567, 64'd5);
		memOp(uCmdLoad, 1'b0, 6'd4, '0, 64'd5);
		memOp(uCmdLoad, 1'b0, 6'd5, '0, 64'd7);
		memOp(uCmdLoad, 1'b0, 6'd6, '0, 64'(MemWords + 3));
		memOp(uCmdStore, 1'b0, 6'd7, 64'h1234, 64'(MemWords));
		for (int f = 0; f < 5; f++) begin
			issueOp(uCmdAlu3, aluFnT'(3'(f)), 1'b0, 6'd1, 6'd2, 6'(10 + f),
				64'hf0f0_1234_8000_0001, 64'h0ff0_4321_8000_0003, '0, '0);
		end
		issueOp(uCmdMul3, aluAdd, 1'b0, 6'd1, 6'd2, 6'd16,
			64'hffff_fffe_0000_0003, 64'h8000_0001_ffff_ffff, '0, '0);
		issueOp(uCmdMovRc, aluAdd, 1'b0, 6'd1, 6'd0, 6'd40, 64'h55aa_0f0f, '0, '0, '0);
		issueOp(uCmdNop, aluAdd, 1'b0, 6'd1, 6'd2, 6'd7, 64'd9, 64'd9, '0, '0);
		// Flushed ops vanish, their neighbours do not
		issueOp(uCmdAlu3, aluAdd, 1'b1, 6'd1, 6'd2, 6'd8, 64'd1, 64'd2, '0, '0);
		issueOp(uCmdAlu3, aluXor, 1'b0, 6'd1, 6'd2, 6'd9, 64'd6, 64'd3, '0, '0);
		memOp(uCmdStore, 1'b1, 6'd3, 64'hbad, 64'd9);
		memOp(uCmdLoad, 1'b0, 6'd11, '0, 64'd9);
		repeat (NumRandom) begin
			randomOp();
		end
		@(negedge clock);
		issue = 1'b0;
		while (expQ.size() != 0 || faultsSeen < faultsExpected) begin
			@(negedge clock);
		end
		repeat (3 + MemWaitCycles + 1) @(negedge clock);	// Catch stray writes
		if (faultsSeen != faultsExpected) begin
			abortRun($sformatf("Saw %0d memory faults but expected %0d",
				faultsSeen, faultsExpected));
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

// File: ExLane.f
hw/ExecPkg.sv
hw/ExStageIf.sv
hw/ExEx1.sv
hw/ExEx2.sv
hw/ExEx3.sv
hw/ExDataMem.sv
hw/ExLane.sv
verification/ExLaneTb.sv

// File: Makefile
# Verilator build and run of the execute lane testbench

.PHONY: run clean

run: obj_dir/VExLaneTb
	@out="$$(./obj_dir/VExLaneTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Result: PASSED'

# Rebuilt only when the file list or a listed source changes
obj_dir/VExLaneTb: ExLane.f $(shell cat ExLane.f)
	verilator --binary --timing --assert -Wno-fatal --top-module ExLaneTb -f ExLane.f

clean:
	rm -rf obj_dir
